/* rtl/dii_channel_pkg.sv */
// Debug interconnect channel types
// Describes what a single flit carries on any link of the ring router
// The first flit of every worm holds the destination node id

package dii_channel_pkg;

  // Width of one flit payload word
  localparam int unsigned FLIT_W = 16;

  // Width of a node address on the debug ring
  localparam int unsigned NODE_ID_W = 16;

  //////////////////////////////////////////////////
  // Flit level types
  //////////////////////////////////////////////////

  // One payload word as it moves over a link
  typedef logic [FLIT_W-1:0] flit_data_t;

  // Node address whose upper bits hold the subnet and whose
  // lower bits select the node inside that subnet
  typedef logic [NODE_ID_W-1:0] node_id_t;

endpackage

/* rtl/ring_router_cfg_pkg.sv */
// Ring router configuration
// Routing and buffering constants shared by the gateway stop

package ring_router_cfg_pkg;

  // Bit position where the subnet field of a node id starts
  localparam int unsigned SUBNET_SHIFT = 10;

  // Entries held by the forwarding FIFO
  localparam int unsigned FWD_FIFO_DEPTH = 4;

  // Address bits plus one wrap bit to tell full from empty
  localparam int unsigned FIFO_PTR_W = $clog2(FWD_FIFO_DEPTH) + 1;

  // Read and write pointer of the forwarding FIFO
  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;

endpackage

/* rtl/dii_channel_if.sv */
// Debug interconnect flit link
// Bundles valid, ready, last and data of one link with source and sink views

`timescale 1ns/1ps

interface dii_channel_if;

  // Source has a flit on the link
  logic valid;
  // Sink takes the flit on this edge
  logic ready;
  // Marks the final flit of a worm
  logic last;
  // Payload word
  dii_channel_pkg::flit_data_t data;

  // Side that drives flits onto the link
  modport source (
    output valid,
    output last,
    output data,
    input  ready
  );

  // Side that consumes flits from the link
  modport sink (
    input  valid,
    input  last,
    input  data,
    output ready
  );

endinterface

/* rtl/ring_ingress_demux.sv */
// Ring ingress demultiplexer
// Steers each worm arriving from the ring to the local port, the external
// gateway port or the forward path, based on the destination in its first flit

`timescale 1ns/1ps

module ring_ingress_demux (
  input  logic                      clk,
  input  logic                      rst,
  input  dii_channel_pkg::node_id_t id,
  dii_channel_if.sink               in,
  dii_channel_if.source             to_local,
  dii_channel_if.source             to_ext,
  dii_channel_if.source             to_fwd
);

  typedef enum logic [1:0] {
    IDLE,
    TO_LOCAL,
    TO_EXT,
    TO_FWD
  } state_t;

  state_t state;
  state_t nxt_state;
  // Route of the flit currently presented on the input
  state_t route;
  // Route the first flit of a new worm asks for
  state_t first_route;
  dii_channel_pkg::node_id_t dest;

  //////////////////////////////////////////////////
  // Route decision
  //////////////////////////////////////////////////

  // The first flit carries the destination address
  assign dest = dii_channel_pkg::node_id_t'(in.data);

  always_comb begin
    first_route = TO_FWD;
    // Exact match means the worm is for this node
    if (dest == id) begin
      first_route = TO_LOCAL;
    end else if ((dest >> ring_router_cfg_pkg::SUBNET_SHIFT) !=
                 (id >> ring_router_cfg_pkg::SUBNET_SHIFT)) begin
      // Another subnet is reached through the external gateway
      first_route = TO_EXT;
    end
  end

  // Between worms the route is decided in the same cycle, inside a worm it is held
  assign route = (state == IDLE) ? first_route : state;

  //////////////////////////////////////////////////
  // Path selection
  //////////////////////////////////////////////////

  always_comb begin
    to_local.valid = 1'b0;
    to_ext.valid   = 1'b0;
    to_fwd.valid   = 1'b0;
    in.ready       = 1'b0;

    // Only the selected path sees valid, and only its ready goes back
    case (route)
      TO_LOCAL: begin
        to_local.valid = in.valid;
        in.ready       = in.valid & to_local.ready;
      end
      TO_EXT: begin
        to_ext.valid = in.valid;
        in.ready     = in.valid & to_ext.ready;
      end
      TO_FWD: begin
        to_fwd.valid = in.valid;
        in.ready     = in.valid & to_fwd.ready;
      end
      default: begin
      end
    endcase
  end

  // Payload goes to all paths, valid alone tells which one owns it
  assign to_local.data = in.data;
  assign to_local.last = in.last;
  assign to_ext.data   = in.data;
  assign to_ext.last   = in.last;
  assign to_fwd.data   = in.data;
  assign to_fwd.last   = in.last;

  always_comb begin
    nxt_state = state;
    if (in.valid && in.ready) begin
      // The worm ends with its last flit, otherwise stay on the chosen path
      nxt_state = in.last ? IDLE : route;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= nxt_state;
    end
  end

endmodule

/* rtl/dii_flit_fifo.sv */
// Forward path flit FIFO
// Circular buffer holding worms that continue along the ring until the
// output arbiter grants them

`timescale 1ns/1ps

module dii_flit_fifo (
  input  logic          clk,
  input  logic          rst,
  dii_channel_if.sink   wr,
  dii_channel_if.source rd
);

  // Storage for payload and the end-of-worm marker
  dii_channel_pkg::flit_data_t data_mem [ring_router_cfg_pkg::FWD_FIFO_DEPTH];
  logic                        last_mem [ring_router_cfg_pkg::FWD_FIFO_DEPTH];

  ring_router_cfg_pkg::fifo_ptr_t                wr_ptr;
  ring_router_cfg_pkg::fifo_ptr_t                rd_ptr;
  logic [ring_router_cfg_pkg::FIFO_PTR_W-2:0]    wr_addr;
  logic [ring_router_cfg_pkg::FIFO_PTR_W-2:0]    rd_addr;
  logic                                          full;
  logic                                          empty;
  logic                                          push;
  logic                                          pop;

  //////////////////////////////////////////////////
  // Pointer compare
  //////////////////////////////////////////////////

  assign wr_addr = wr_ptr[ring_router_cfg_pkg::FIFO_PTR_W-2:0];
  assign rd_addr = rd_ptr[ring_router_cfg_pkg::FIFO_PTR_W-2:0];

  // Same address with differing wrap bits means the writer lapped the reader
  assign full  = (wr_addr == rd_addr) &&
                 (wr_ptr[ring_router_cfg_pkg::FIFO_PTR_W-1] !=
                  rd_ptr[ring_router_cfg_pkg::FIFO_PTR_W-1]);
  assign empty = (wr_ptr == rd_ptr);

  assign push = wr.valid & ~full;
  assign pop  = rd.ready & ~empty;

  // Link side of the buffer
  assign wr.ready = ~full;
  assign rd.valid = ~empty;
  assign rd.data  = data_mem[rd_addr];
  assign rd.last  = last_mem[rd_addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + ring_router_cfg_pkg::fifo_ptr_t'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + ring_router_cfg_pkg::fifo_ptr_t'(1);
      end
    end
  end

  // A written flit shows up at the read side on the next cycle
  always_ff @(posedge clk) begin
    if (push) begin
      data_mem[wr_addr] <= wr.data;
      last_mem[wr_addr] <= wr.last;
    end
  end

endmodule

/* rtl/ring_gateway_mux.sv */
// Ring output arbiter
// Merges forwarded, local and external worms onto the ring output with
// fixed priority, keeping each worm contiguous from first to last flit

`timescale 1ns/1ps

module ring_gateway_mux (
  input  logic          clk,
  input  logic          rst,
  dii_channel_if.sink   in_ring,
  dii_channel_if.sink   in_local,
  dii_channel_if.sink   in_ext,
  dii_channel_if.source out_mux
);

  typedef enum logic [1:0] {
    NOWORM,
    WORM_RING,
    WORM_LOCAL,
    WORM_EXT
  } state_t;

  state_t state;
  state_t nxt_state;
  // Source that owns the output in this cycle
  state_t grant;

  //////////////////////////////////////////////////
  // Grant
  //////////////////////////////////////////////////

  always_comb begin
    grant = state;
    // Without a worm in flight pick the highest priority valid source
    if (state == NOWORM) begin
      if (in_ring.valid) begin
        grant = WORM_RING;
      end else if (in_local.valid) begin
        grant = WORM_LOCAL;
      end else if (in_ext.valid) begin
        grant = WORM_EXT;
      end
    end
  end

  //////////////////////////////////////////////////
  // Output select
  //////////////////////////////////////////////////

  always_comb begin
    out_mux.valid  = 1'b0;
    out_mux.data   = '0;
    out_mux.last   = 1'b0;
    in_ring.ready  = 1'b0;
    in_local.ready = 1'b0;
    in_ext.ready   = 1'b0;

    // Only the granted source is handed the output ready
    case (grant)
      WORM_RING: begin
        out_mux.valid = in_ring.valid;
        out_mux.data  = in_ring.data;
        out_mux.last  = in_ring.last;
        in_ring.ready = out_mux.ready;
      end
      WORM_LOCAL: begin
        out_mux.valid  = in_local.valid;
        out_mux.data   = in_local.data;
        out_mux.last   = in_local.last;
        in_local.ready = out_mux.ready;
      end
      WORM_EXT: begin
        out_mux.valid = in_ext.valid;
        out_mux.data  = in_ext.data;
        out_mux.last  = in_ext.last;
        in_ext.ready  = out_mux.ready;
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    // Lock onto the granted source once it has been picked
    nxt_state = grant;
    // An accepted last flit frees the output for the next worm
    if (out_mux.valid && out_mux.ready && out_mux.last) begin
      nxt_state = NOWORM;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= NOWORM;
    end else begin
      state <= nxt_state;
    end
  end

endmodule

/* rtl/ring_router_gateway.sv */
// Ring router gateway stop
// Splits worms from the ring into local, external and forward traffic and
// merges forward, local and external worms back onto the ring output

`timescale 1ns/1ps

module ring_router_gateway (
  input  logic                        clk,
  input  logic                        rst,
  input  dii_channel_pkg::node_id_t   id,

  input  logic                        ring_in_valid,
  input  dii_channel_pkg::flit_data_t ring_in_data,
  input  logic                        ring_in_last,
  output logic                        ring_in_ready,
  input  logic                        local_in_valid,
  input  dii_channel_pkg::flit_data_t local_in_data,
  input  logic                        local_in_last,
  output logic                        local_in_ready,
  input  logic                        ext_in_valid,
  input  dii_channel_pkg::flit_data_t ext_in_data,
  input  logic                        ext_in_last,
  output logic                        ext_in_ready,

  output logic                        ring_out_valid,
  output dii_channel_pkg::flit_data_t ring_out_data,
  output logic                        ring_out_last,
  input  logic                        ring_out_ready,
  output logic                        local_out_valid,
  output dii_channel_pkg::flit_data_t local_out_data,
  output logic                        local_out_last,
  input  logic                        local_out_ready,
  output logic                        ext_out_valid,
  output dii_channel_pkg::flit_data_t ext_out_data,
  output logic                        ext_out_last,
  input  logic                        ext_out_ready
);

  // Inbound links
  dii_channel_if from_ring ();
  dii_channel_if from_local ();
  dii_channel_if from_ext ();
  // Demux outputs and the forward path through the FIFO
  dii_channel_if to_local ();
  dii_channel_if to_ext ();
  dii_channel_if to_fwd ();
  dii_channel_if fwd ();
  // Arbiter output towards the ring
  dii_channel_if merged ();

  //////////////////////////////////////////////////
  // Port mapping
  //////////////////////////////////////////////////

  assign from_ring.valid  = ring_in_valid;
  assign from_ring.data   = ring_in_data;
  assign from_ring.last   = ring_in_last;
  assign ring_in_ready    = from_ring.ready;
  assign from_local.valid = local_in_valid;
  assign from_local.data  = local_in_data;
  assign from_local.last  = local_in_last;
  assign local_in_ready   = from_local.ready;
  assign from_ext.valid   = ext_in_valid;
  assign from_ext.data    = ext_in_data;
  assign from_ext.last    = ext_in_last;
  assign ext_in_ready     = from_ext.ready;

  assign local_out_valid = to_local.valid;
  assign local_out_data  = to_local.data;
  assign local_out_last  = to_local.last;
  assign to_local.ready  = local_out_ready;
  assign ext_out_valid   = to_ext.valid;
  assign ext_out_data    = to_ext.data;
  assign ext_out_last    = to_ext.last;
  assign to_ext.ready    = ext_out_ready;
  assign ring_out_valid  = merged.valid;
  assign ring_out_data   = merged.data;
  assign ring_out_last   = merged.last;
  assign merged.ready    = ring_out_ready;

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  ring_ingress_demux u_demux (
    .clk      (clk),
    .rst      (rst),
    .id       (id),
    .in       (from_ring),
    .to_local (to_local),
    .to_ext   (to_ext),
    .to_fwd   (to_fwd)
  );

  // Forwarded worms wait here while another worm holds the ring output
  dii_flit_fifo u_fwd_fifo (
    .clk (clk),
    .rst (rst),
    .wr  (to_fwd),
    .rd  (fwd)
  );

  ring_gateway_mux u_mux (
    .clk      (clk),
    .rst      (rst),
    .in_ring  (fwd),
    .in_local (from_local),
    .in_ext   (from_ext),
    .out_mux  (merged)
  );

endmodule

/* verification/ring_router_gateway_chk.sv */
// Ring router gateway checker
// Watches the three outbound links for stable flits under a stall,
// a quiet reset and known payload on the ring output

`timescale 1ns/1ps

module ring_router_gateway_chk (
  input logic                        clk,
  input logic                        rst,
  input logic                        ring_out_valid,
  input dii_channel_pkg::flit_data_t ring_out_data,
  input logic                        ring_out_last,
  input logic                        ring_out_ready,
  input logic                        local_out_valid,
  input dii_channel_pkg::flit_data_t local_out_data,
  input logic                        local_out_last,
  input logic                        local_out_ready,
  input logic                        ext_out_valid,
  input dii_channel_pkg::flit_data_t ext_out_data,
  input logic                        ext_out_last,
  input logic                        ext_out_ready
);

  //////////////////////////////////////////////////
  // Stall stability
  //////////////////////////////////////////////////

  // A stalled flit stays on the link unchanged until the sink takes it
  a_ring_hold: assert property (@(posedge clk) disable iff (rst)
    ring_out_valid && !ring_out_ready |=> ring_out_valid &&
    $stable({ring_out_last, ring_out_data})) else $error("ring_out flit changed during a stall");
  a_local_hold: assert property (@(posedge clk) disable iff (rst)
    local_out_valid && !local_out_ready |=> local_out_valid &&
    $stable({local_out_last, local_out_data})) else $error("local_out flit changed during a stall");
  a_ext_hold: assert property (@(posedge clk) disable iff (rst)
    ext_out_valid && !ext_out_ready |=> ext_out_valid &&
    $stable({ext_out_last, ext_out_data})) else $error("ext_out flit changed during a stall");

  //////////////////////////////////////////////////
  // Reset and payload
  //////////////////////////////////////////////////

  // Once reset has been seen on an edge no output may offer a flit
  a_reset_quiet: assert property (@(posedge clk)
    rst && $past(rst) |-> !(ring_out_valid || local_out_valid || ext_out_valid))
    else $error("an output valid was high during reset");

  // Flits read back from the forwarding FIFO through the arbiter carry no unknown bits
  a_ring_known: assert property (@(posedge clk) disable iff (rst)
    ring_out_valid |-> !$isunknown({ring_out_last, ring_out_data}))
    else $error("ring_out carried unknown payload");

endmodule

// Attach the checker to every gateway instance
bind ring_router_gateway ring_router_gateway_chk u_chk (.*);

/* verification/ring_router_gateway_tb.sv */
// Ring router gateway testbench
// Reads worms from the tests file, drives them into the three inbound ports,
// predicts the output port of every worm and checks each flit that leaves

`timescale 1ns/1ps

module ring_router_gateway_tb;

  // Address strapped onto this node that the ring worms in the tests file route against
  localparam logic [15:0] NODE_ID = 16'h0c05;

  logic clk;
  logic rst;
  dii_channel_pkg::node_id_t id;
  // Inbound side uses index 0 for ring, 1 for local and 2 for ext
  logic in_valid [3];
  dii_channel_pkg::flit_data_t in_data [3];
  logic in_last [3];
  logic in_ready [3];
  // Outbound side uses index 0 for local, 1 for ext and 2 for ring
  logic out_valid [3];
  dii_channel_pkg::flit_data_t out_data [3];
  logic out_last [3];
  logic out_ready [3];

  // Expected {last, data} per output with ring_out split by source into 2 fwd, 3 local and 4 ext
  logic [16:0] exp_q [5][$];
  string exp_name [5][$];
  // Flits still to be driven per inbound port
  logic [16:0] src_q [3][$];
  logic [15:0] lfsr;
  int mismatch_count;
  int other_count;
  int total_flits;

  ring_router_gateway dut0 (
    .clk (clk), .rst (rst), .id (id),
    .ring_in_valid (in_valid[0]), .ring_in_data (in_data[0]),
    .ring_in_last (in_last[0]), .ring_in_ready (in_ready[0]),
    .local_in_valid (in_valid[1]), .local_in_data (in_data[1]),
    .local_in_last (in_last[1]), .local_in_ready (in_ready[1]),
    .ext_in_valid (in_valid[2]), .ext_in_data (in_data[2]),
    .ext_in_last (in_last[2]), .ext_in_ready (in_ready[2]),
    .local_out_valid (out_valid[0]), .local_out_data (out_data[0]),
    .local_out_last (out_last[0]), .local_out_ready (out_ready[0]),
    .ext_out_valid (out_valid[1]), .ext_out_data (out_data[1]),
    .ext_out_last (out_last[1]), .ext_out_ready (out_ready[1]),
    .ring_out_valid (out_valid[2]), .ring_out_data (out_data[2]),
    .ring_out_last (out_last[2]), .ring_out_ready (out_ready[2])
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Random source and checking
  //////////////////////////////////////////////////

  // Fibonacci LFSR with taps 16, 14, 13 and 11 that steps once per bit taken
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [15:0] lfsr_word();
    logic [15:0] w;
    w = '0;
    for (int i = 0; i < 16; i++) begin
      w = {w[14:0], lfsr_step()};
    end
    return w;
  endfunction

  task automatic check_value(string test, logic [16:0] expected, logic [16:0] actual);
    if (expected !== actual) begin
      mismatch_count++;
      $display("MISMATCH %s expected %h actual %h", test, expected, actual);
    end
  endtask

  function automatic int flits_left();
    int n;
    n = 0;
    for (int q = 0; q < 5; q++) begin
      n += exp_q[q].size();
    end
    return n;
  endfunction

  // Closing summary and end of the run
  task automatic report_and_finish();
    $display("mismatches %0d, other errors %0d", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  //////////////////////////////////////////////////
  // Tests file and routing model
  //////////////////////////////////////////////////

  task automatic add_worm(string name, string src, logic [15:0] dest, int len);
    int sp;
    int op;
    logic [16:0] flit;
    sp = (src == "ring") ? 0 : (src == "local") ? 1 : (src == "ext") ? 2 : -1;
    if (sp < 0 || len < 1) begin
      other_count++;
      $display("test %s has an unknown source port or no flits", name);
      return;
    end
    // Ring worms split by destination while injected worms always go back onto the ring
    op = sp + 2;
    if (sp == 0 && dest == NODE_ID) begin
      op = 0;
    end else if (sp == 0 && (dest >> ring_router_cfg_pkg::SUBNET_SHIFT) !=
                 (NODE_ID >> ring_router_cfg_pkg::SUBNET_SHIFT)) begin
      op = 1;
    end
    for (int i = 0; i < len; i++) begin
      flit[15:0] = dest;
      if (i != 0) begin
        flit[15:0] = lfsr_word();
      end
      flit[16] = (i == len - 1);
      src_q[sp].push_back(flit);
      exp_q[op].push_back(flit);
      exp_name[op].push_back(name);
    end
    total_flits += len;
  endtask

  task automatic load_tests();
    int fd;
    int rc;
    int len;
    string line;
    string name;
    string src;
    logic [15:0] dest;
    fd = $fopen("verification/ring_router_gateway_tests.txt", "r");
    if (fd == 0) begin
      other_count++;
      $display("the tests file could not be opened");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      rc = $sscanf(line, "%s %s %h %d", name, src, dest, len);
      if (rc != 4) begin
        other_count++;
        $display("a line of the tests file could not be parsed");
      end else begin
        add_worm(name, src, dest, len);
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////
  // Drivers and monitors
  //////////////////////////////////////////////////

  task automatic drive_port(input int p);
    logic [16:0] flit;
    while (src_q[p].size() > 0) begin
      flit = src_q[p].pop_front();
      in_valid[p] = 1'b1;
      in_data[p] = flit[15:0];
      in_last[p] = flit[16];
      // Ready is settled at the falling edge and the flit moves on the next rising edge
      do begin
        @(negedge clk);
      end while (!in_ready[p]);
      @(posedge clk);
      #2;
    end
    in_valid[p] = 1'b0;
  endtask

  task automatic drive_ready();
    forever begin
      @(posedge clk);
      #2;
      for (int p = 0; p < 3; p++) begin
        out_ready[p] = lfsr_step();
      end
    end
  endtask

  // The first flit of a worm on ring_out tells which source queue it belongs to
  function automatic int pick_ring_source(logic [15:0] first);
    int q;
    logic [16:0] head;
    q = 2;
    for (int s = 4; s >= 2; s--) begin
      if (exp_q[s].size() > 0) begin
        head = exp_q[s][0];
        if (head[15:0] == first) q = s;
      end
    end
    return q;
  endfunction

  task automatic watch_output(input int p);
    logic [16:0] got;
    logic in_worm;
    int q;
    in_worm = 1'b0;
    q = p;
    forever begin
      @(negedge clk);
      if (!rst && out_valid[p] && out_ready[p]) begin
        got = {out_last[p], out_data[p]};
        if (p == 2 && !in_worm) q = pick_ring_source(got[15:0]);
        if (exp_q[q].size() == 0) begin
          other_count++;
          $display("output %0d delivered flit %h that no test expects", p, got);
        end else begin
          check_value(exp_name[q].pop_front(), exp_q[q].pop_front(), got);
        end
        in_worm = !got[16];
      end
    end
  endtask

  task automatic watchdog(input int cycles);
    repeat (cycles) @(posedge clk);
    other_count++;
    $display("timeout after %0d cycles with %0d flits never seen", cycles, flits_left());
    report_and_finish();
  endtask

  initial begin
    rst = 1'b1;
    id = NODE_ID;
    for (int p = 0; p < 3; p++) begin
      in_valid[p] = 1'b0;
      in_data[p] = '0;
      in_last[p] = 1'b0;
      out_ready[p] = 1'b0;
    end
    mismatch_count = 0;
    other_count = 0;
    total_flits = 0;
    lfsr = 16'd48194;
    load_tests();
    fork
      watchdog(40 * total_flits + 200);
    join_none
    // Output valids stay low through the four reset edges and right after them
    repeat (3) begin
      @(posedge clk);
      @(negedge clk);
      check_value("reset", '0, {14'b0, out_valid[2], out_valid[1], out_valid[0]});
    end
    @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    check_value("after_reset", '0, {14'b0, out_valid[2], out_valid[1], out_valid[0]});
    @(posedge clk);
    #2;
    fork
      watch_output(0);
      watch_output(1);
      watch_output(2);
      drive_ready();
    join_none
    fork
      drive_port(0);
      drive_port(1);
      drive_port(2);
    join
    while (flits_left() != 0) @(negedge clk);
    // A few more cycles catch any duplicated flit
    repeat (4) @(negedge clk);
    report_and_finish();
  end

endmodule

/* verification/ring_router_gateway_tests.txt */
# name source destination length: source is ring, local or ext, destination is hex
# ring worms route against node id 0c05, payload flits after the first are random
ring_to_local_a  ring  0c05 3
ring_to_ext_a    ring  1005 4
ring_fwd_a       ring  0c12 5
local_a          local 0c20 3
ext_a            ext   0c21 4
ring_fwd_long    ring  0c33 9
local_b          local 0400 6
ring_to_local_b  ring  0c05 1
ext_b            ext   2001 5
ring_fwd_b       ring  0d00 2
ring_to_ext_b    ring  0405 3
local_c          local 0c40 2
ring_fwd_c       ring  0fff 7
ext_c            ext   0c41 1
ring_to_local_c  ring  0c05 6
ring_fwd_d       ring  0c06 4
local_d          local 0c50 5
ext_d            ext   3c05 3
ring_to_ext_c    ring  8c05 2
ring_fwd_e       ring  0e21 6
ring_fwd_f       ring  0c04 1
local_e          local 0c60 1
ext_e            ext   0c61 7
ring_to_local_d  ring  0c05 4

/* ring_router_gateway.f */
rtl/dii_channel_pkg.sv
rtl/ring_router_cfg_pkg.sv
rtl/dii_channel_if.sv
rtl/ring_ingress_demux.sv
rtl/dii_flit_fifo.sv
rtl/ring_gateway_mux.sv
rtl/ring_router_gateway.sv
verification/ring_router_gateway_chk.sv
verification/ring_router_gateway_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the ring router gateway testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module ring_router_gateway_tb \
  -f ring_router_gateway.f -o ring_router_gateway_sim \
  && ./obj_dir/ring_router_gateway_sim > sim.log 2>&1 \
  || echo "build or simulation did not complete" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0
